// ==== hw/adc_acq_pkg.sv ====
`default_nettype none

package adc_acq_pkg;

	//////////////////////////////////////////////////
	// adc geometry

	localparam int W_SAMPLE    = 18;                  // bits per adc code
	localparam int N_CHAN      = 8;                   // channels per conversion
	localparam int W_CHAN      = 3;                   // channel index width
	localparam int N_LANE_CHAN = N_CHAN / 2;          // channels per serial lane
	localparam int W_BIT_CNT   = $clog2(W_SAMPLE);    // bit position within a word
	localparam int W_WORD_CNT  = $clog2(N_LANE_CHAN); // word position within a lane

	//////////////////////////////////////////////////
	// timing, clk_in cycles

	localparam int MIN_T_CYCLE = 85;                        // convst to convst minimum
	localparam int T_READ      = 2 * W_SAMPLE * N_LANE_CHAN + 4; // readout window after busy
	localparam int W_TIMER     = 8;                         // holds MIN_T_CYCLE and T_READ

	localparam logic [2:0] OS_MIN = 3'd1;  // lowest legal oversampling code
	localparam logic [2:0] OS_MAX = 3'd6;  // highest legal oversampling code

	//////////////////////////////////////////////////
	// buffer and flow control

	localparam int BUF_DEPTH   = 16;                 // power of two, pointers wrap
	localparam int W_PTR       = $clog2(BUF_DEPTH);
	localparam int W_BUF_CNT   = 5;                  // fill, free and credit counts
	localparam int CREDIT_INIT = 4;                  // credits granted at reset

	typedef struct packed {
		logic [W_CHAN-1:0]          chan;  // channel number
		logic signed [W_SAMPLE-1:0] code;  // two's complement adc code
	} sample_word_t;

endpackage

`default_nettype wire

// ==== hw/adc_conv_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module adc_conv_ctrl import adc_acq_pkg::*; (
	input  wire                 clk_in,
	input  wire                 reset_in,
	input  wire                 busy,        // adc conversion busy
	input  wire  [2:0]          os_value,    // requested oversampling code
	input  wire                 os_update,   // load os_value
	input  wire                 conv_start,  // enter continuous mode
	input  wire                 conv_stop,   // leave continuous mode
	input  wire  [W_BUF_CNT-1:0] free_count, // room left in word buffer
	output logic                convst,      // active low start pulse
	output logic [2:0]          os           // oversampling pins
);

	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,  // not converting
		ST_CONVST = 2'd1,  // convst low this cycle
		ST_CONV   = 2'd2   // conversion and readout in flight
	} state_t;

	state_t             state;
	logic               run;        // continuous mode requested
	logic               busy_q;     // busy one cycle late
	logic               busy_fall;
	logic               conv_done;  // busy fell since last convst
	logic [W_TIMER-1:0] cyc_cnt;    // cycles since last convst, saturates
	logic [W_TIMER-1:0] rd_wait;    // reader still clocking out data
	logic               start_ok;

	assign busy_fall = busy_q & ~busy;

	// every condition for the next convst pulse
	assign start_ok = run && conv_done && !busy && (rd_wait == '0)
		&& (cyc_cnt >= W_TIMER'(MIN_T_CYCLE - 1))
		&& (free_count >= W_BUF_CNT'(N_CHAN)); // room for a whole frame

	//////////////////////////////////////////////////
	// oversampling register

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			os <= OS_MIN;
		end else if (os_update) begin
			if (os_value < OS_MIN)
				os <= OS_MIN;               // clamp low
			else if (os_value > OS_MAX)
				os <= OS_MAX;               // clamp high
			else
				os <= os_value;
		end
	end

	//////////////////////////////////////////////////
	// run flag and fsm

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			run    <= 1'b0;
			state  <= ST_IDLE;
			convst <= 1'b1;
		end else begin
			if (conv_stop)
				run <= 1'b0;                // stop wins over start
			else if (conv_start)
				run <= 1'b1;
			convst <= 1'b1;                 // high unless starting
			case (state)
				ST_IDLE: begin
					if (start_ok) begin
						state  <= ST_CONVST;
						convst <= 1'b0;
					end
				end
				ST_CONVST: begin
					state <= ST_CONV;           // single cycle pulse
				end
				ST_CONV: begin
					if (!run) begin
						state <= ST_IDLE;
					end else if (start_ok) begin
						state  <= ST_CONVST;
						convst <= 1'b0;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// cycle and readout timers

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			busy_q    <= 1'b0;
			conv_done <= 1'b1;                       // first start needs no busy
			cyc_cnt   <= W_TIMER'(MIN_T_CYCLE - 1);  // first start not delayed
			rd_wait   <= '0;
		end else begin
			busy_q <= busy;
			if (!convst) begin
				cyc_cnt   <= W_TIMER'(1);            // pulse cycle counts as 0
				conv_done <= 1'b0;
			end else if (cyc_cnt != '1) begin
				cyc_cnt <= cyc_cnt + 1'b1;
			end
			if (busy_fall) begin
				conv_done <= 1'b1;
				rd_wait   <= W_TIMER'(T_READ);       // reader starts now
			end else if (rd_wait != '0) begin
				rd_wait <= rd_wait - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/adc_serial_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module adc_serial_reader import adc_acq_pkg::*; (
	input  wire          clk_in,
	input  wire          reset_in,
	input  wire          busy,        // adc conversion busy
	input  wire          data_a,      // lane a, channels 0 to 3
	input  wire          data_b,      // lane b, channels 4 to 7
	output logic         n_cs,        // adc chip select, active low
	output logic         sclk,        // serial clock, half clk_in rate
	output logic         word_valid,  // word holds a new channel word
	output sample_word_t word
);

	logic                  busy_q;    // busy one cycle late
	logic                  active;    // frame readout in progress
	logic                  last_bit;  // final bit of frame sampled
	logic [W_BIT_CNT-1:0]  bit_cnt;   // bit within current word
	logic [W_WORD_CNT-1:0] word_cnt;  // word within current lane
	logic                  b_pend;    // lane b word goes out next cycle
	logic                  word_end;
	logic [W_SAMPLE-1:0]   shift_a;
	logic [W_SAMPLE-1:0]   shift_b;
	sample_word_t          word_b;    // lane b word held one cycle

	assign word_end = (bit_cnt == W_BIT_CNT'(W_SAMPLE - 1));

	//////////////////////////////////////////////////
	// chip select, sclk and counters

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			busy_q     <= 1'b0;
			active     <= 1'b0;
			last_bit   <= 1'b0;
			n_cs       <= 1'b1;
			sclk       <= 1'b0;
			bit_cnt    <= '0;
			word_cnt   <= '0;
			b_pend     <= 1'b0;
			word_valid <= 1'b0;
		end else begin
			busy_q     <= busy;
			word_valid <= b_pend;             // lane b follows lane a
			b_pend     <= 1'b0;
			if (!active) begin
				if (busy_q && !busy) begin      // conversion finished
					active <= 1'b1;
					n_cs   <= 1'b0;
				end
			end else if (!sclk) begin         // sclk rising, lanes sampled
				sclk <= 1'b1;
				if (word_end) begin
					bit_cnt    <= '0;
					word_cnt   <= word_cnt + 1'b1;  // wraps after lane's last word
					word_valid <= 1'b1;
					b_pend     <= 1'b1;
					last_bit   <= (word_cnt == W_WORD_CNT'(N_LANE_CHAN - 1));
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else begin                    // sclk falling
				sclk <= 1'b0;
				if (last_bit) begin
					active   <= 1'b0;
					last_bit <= 1'b0;
					n_cs     <= 1'b1;             // frame done
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// shift registers and word assembly

	always_ff @(posedge clk_in) begin
		if (active && !sclk) begin
			shift_a <= {shift_a[W_SAMPLE-2:0], data_a};  // msb first
			shift_b <= {shift_b[W_SAMPLE-2:0], data_b};
			if (word_end) begin
				word.chan   <= W_CHAN'(word_cnt);
				word.code   <= {shift_a[W_SAMPLE-2:0], data_a};
				word_b.chan <= W_CHAN'(word_cnt) + W_CHAN'(N_LANE_CHAN);
				word_b.code <= {shift_b[W_SAMPLE-2:0], data_b};
			end
		end
		if (b_pend)
			word <= word_b;                   // second word of the pair
	end

endmodule

`default_nettype wire

// ==== hw/adc_word_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module adc_word_buffer import adc_acq_pkg::*; (
	input  wire                  clk_in,
	input  wire                  reset_in,
	input  wire                  word_valid,     // write strobe from reader
	input  wire  sample_word_t   word,           // channel word to store
	input  wire                  credit_return,  // consumer frees one credit
	output logic [W_BUF_CNT-1:0] free_count,     // empty slots
	output logic                 sample_valid,   // word out this cycle
	output sample_word_t         sample_word
);

	sample_word_t         mem [BUF_DEPTH];  // word storage
	logic [W_PTR-1:0]     wr_ptr;
	logic [W_PTR-1:0]     rd_ptr;
	logic [W_BUF_CNT-1:0] fill;             // words held
	logic [W_BUF_CNT-1:0] credits;          // words the consumer can take
	logic                 wr_en;
	logic                 rd_en;
	logic                 credit_up;

	// control never starts a frame without room, full guard keeps pointers sane
	assign wr_en     = word_valid && (fill != W_BUF_CNT'(BUF_DEPTH));
	assign rd_en     = (fill != '0) && (credits != '0);  // one pop per cycle
	assign credit_up = credit_return && (credits != '1); // saturate

	assign free_count   = W_BUF_CNT'(BUF_DEPTH) - fill;
	assign sample_valid = rd_en;
	assign sample_word  = mem[rd_ptr];      // head word, valid with rd_en

	//////////////////////////////////////////////////
	// storage

	always_ff @(posedge clk_in) begin
		if (wr_en)
			mem[wr_ptr] <= word;
	end

	//////////////////////////////////////////////////
	// pointers, fill and credits

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			fill    <= '0;
			credits <= W_BUF_CNT'(CREDIT_INIT);
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;      // natural wrap
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;        // both or neither
			endcase
			case ({credit_up, rd_en})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;  // word spent a credit
				default: credits <= credits;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/adc_acq_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module adc_acq_top import adc_acq_pkg::*; (
	input  wire          clk_in,
	input  wire          reset_in,
	// adc pins
	output logic         convst,         // active low
	output logic         n_cs,
	output logic         sclk,
	output logic [2:0]   os,
	output logic         adc_reset,
	input  wire          busy,
	input  wire          data_a,
	input  wire          data_b,
	// host controls
	input  wire  [2:0]   os_value,
	input  wire          os_update,
	input  wire          conv_start,
	input  wire          conv_stop,
	// consumer
	output logic         sample_valid,
	output sample_word_t sample_word,
	input  wire          credit_return
);

	logic [W_BUF_CNT-1:0] free_count;  // buffer room, gates convst
	logic                 word_valid;  // reader to buffer
	sample_word_t         word;

	assign adc_reset = reset_in;       // adc held in reset with the logic

	adc_conv_ctrl u_conv_ctrl (
		.clk_in     (clk_in),
		.reset_in   (reset_in),
		.busy       (busy),
		.os_value   (os_value),
		.os_update  (os_update),
		.conv_start (conv_start),
		.conv_stop  (conv_stop),
		.free_count (free_count),
		.convst     (convst),
		.os         (os)
	);

	adc_serial_reader u_serial_reader (
		.clk_in     (clk_in),
		.reset_in   (reset_in),
		.busy       (busy),
		.data_a     (data_a),
		.data_b     (data_b),
		.n_cs       (n_cs),
		.sclk       (sclk),
		.word_valid (word_valid),
		.word       (word)
	);

	adc_word_buffer u_word_buffer (
		.clk_in        (clk_in),
		.reset_in      (reset_in),
		.word_valid    (word_valid),
		.word          (word),
		.credit_return (credit_return),
		.free_count    (free_count),
		.sample_valid  (sample_valid),
		.sample_word   (sample_word)
	);

endmodule

`default_nettype wire

// ==== verif/ad7608_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module ad7608_model import adc_acq_pkg::*; (
	input  wire  clk_in,
	input  wire  adc_reset,
	input  wire  convst,     // active low start
	input  wire  n_cs,
	input  wire  sclk,
	output logic busy,
	output logic data_a,     // channels 0 to 3
	output logic data_b      // channels 4 to 7
);

	localparam int T_BUSY  = 40;                     // conversion time, clk_in cycles
	localparam int W_FRAME = W_SAMPLE * N_CHAN / 2;  // bits per lane per conversion

	int                 conv_num;   // conversion counter k
	int                 busy_cnt;
	int                 bit_idx;    // next frame bit to drive
	logic               ncs_q;      // pins seen at the previous falling edge
	logic               sclk_q;
	logic [W_FRAME-1:0] frame_a;
	logic [W_FRAME-1:0] frame_b;

	// code for channel c of conversion k, wraps at 18 bits
	function automatic logic [W_SAMPLE-1:0] channel_code(int k, int c);
		return W_SAMPLE'((k * N_CHAN + c) * 997);
	endfunction

	//////////////////////////////////////////////////
	// all pins move on the falling clk_in edge

	initial begin
		busy   = 1'b0;
		data_a = 1'b0;
		data_b = 1'b0;
		forever begin
			@(negedge clk_in);
			if (adc_reset) begin
				busy     = 1'b0;
				data_a   = 1'b0;
				data_b   = 1'b0;
				conv_num = 0;
				busy_cnt = 0;
				bit_idx  = -1;
				ncs_q    = 1'b1;
				sclk_q   = 1'b0;
			end else begin
				if (!busy && !convst) begin                // convst seen, sample all channels
					for (int c = 0; c < N_CHAN / 2; c++) begin
						frame_a[W_FRAME - 1 - c * W_SAMPLE -: W_SAMPLE] = channel_code(conv_num, c);
						frame_b[W_FRAME - 1 - c * W_SAMPLE -: W_SAMPLE] =
							channel_code(conv_num, c + N_CHAN / 2);
					end
					conv_num++;
					busy     = 1'b1;
					busy_cnt = T_BUSY;
				end else if (busy) begin
					busy_cnt--;
					if (busy_cnt == 0)
						busy = 1'b0;                           // conversion done
				end
				if (!n_cs && ncs_q) begin                  // cs falling, msb out
					data_a  = frame_a[W_FRAME-1];
					data_b  = frame_b[W_FRAME-1];
					bit_idx = W_FRAME - 2;
				end else if (!n_cs && sclk_q && !sclk && bit_idx >= 0) begin
					data_a  = frame_a[bit_idx];              // next bit after sclk falls
					data_b  = frame_b[bit_idx];
					bit_idx--;
				end
				ncs_q  = n_cs;
				sclk_q = sclk;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verif/tb_adc_acq.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_adc_acq import adc_acq_pkg::*; ();

	localparam int WORD_TIMEOUT  = 600;   // cycles per word
	localparam int PULSE_TIMEOUT = 2000;  // cycles per pulse wait
	localparam int STALL_WINDOW  = 1000;  // cycles to watch a stall
	localparam int CONT_FRAMES   = 4;

	logic         clk_in;
	logic         reset_in;
	logic         convst;
	logic         n_cs;
	logic         sclk;
	logic [2:0]   os;
	logic         adc_reset;
	logic         busy;
	logic         data_a;
	logic         data_b;
	logic [2:0]   os_value;
	logic         os_update;
	logic         conv_start;
	logic         conv_stop;
	logic         sample_valid;
	sample_word_t sample_word;
	logic         credit_return;

	int           mismatch_count = 0;
	int           fault_count    = 0;
	int           cycle_num      = 0;
	int           pulse_count    = 0;   // convst low pulses seen
	int           last_pulse_cyc = 0;
	int           words_seen     = 0;
	int           word_num       = 0;   // next expected word in the stream
	int           extra_credits  = 0;   // credits to return regardless of words
	bit           auto_credit    = 1'b0; // return one credit per word
	logic         convst_q       = 1'b1;
	sample_word_t got_q [$];

	adc_acq_top dut (
		.clk_in        (clk_in),
		.reset_in      (reset_in),
		.convst        (convst),
		.n_cs          (n_cs),
		.sclk          (sclk),
		.os            (os),
		.adc_reset     (adc_reset),
		.busy          (busy),
		.data_a        (data_a),
		.data_b        (data_b),
		.os_value      (os_value),
		.os_update     (os_update),
		.conv_start    (conv_start),
		.conv_stop     (conv_stop),
		.sample_valid  (sample_valid),
		.sample_word   (sample_word),
		.credit_return (credit_return)
	);

	ad7608_model adc_model (
		.clk_in    (clk_in),
		.adc_reset (adc_reset),
		.convst    (convst),
		.n_cs      (n_cs),
		.sclk      (sclk),
		.busy      (busy),
		.data_a    (data_a),
		.data_b    (data_b)
	);

	initial begin
		clk_in = 1'b0;
		forever #10 clk_in = ~clk_in;  // 20 ns period
	end

	//////////////////////////////////////////////////
	// checks and expected values

	task automatic note_failure(string msg);
		$display("error at %0t: %s", $time, msg);
		fault_count++;
	endtask

	task automatic compare_word(string name, sample_word_t got, sample_word_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got chan %0d code %05h expected chan %0d code %05h",
				$time, name, got.chan, got.code, exp.chan, exp.code);
			mismatch_count++;
		end
	endtask

	task automatic compare_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic compare_os(string name, logic [2:0] got, logic [2:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
			mismatch_count++;
		end
	endtask

	// word n of the stream, lanes interleave 0 4 1 5 2 6 3 7
	function automatic sample_word_t expected_word(int n);
		int           k;
		int           pos;
		int           chan;
		int           value;
		sample_word_t w;
		k     = n / N_CHAN;
		pos   = n % N_CHAN;
		chan  = (pos % 2 == 0) ? pos / 2 : pos / 2 + N_CHAN / 2;
		value = ((k * N_CHAN + chan) * 997) % (1 << W_SAMPLE);
		w.chan = chan[W_CHAN-1:0];
		w.code = value[W_SAMPLE-1:0];
		return w;
	endfunction

	//////////////////////////////////////////////////
	// consumer and convst monitor, falling edge

	initial begin
		credit_return = 1'b0;
		forever begin
			@(negedge clk_in);
			cycle_num++;
			credit_return = 1'b0;
			if (!reset_in) begin
				if (sample_valid) begin
					got_q.push_back(sample_word);
					words_seen++;
				end
				if (sample_valid && auto_credit) begin
					credit_return = 1'b1;          // pay back the spent credit
				end else if (extra_credits > 0) begin
					credit_return = 1'b1;
					extra_credits--;
				end
				if (!convst) begin
					if (!convst_q)
						note_failure("convst held low for more than one cycle");
					else if (pulse_count > 0 && cycle_num - last_pulse_cyc < MIN_T_CYCLE)
						note_failure($sformatf("convst pulses only %0d cycles apart",
							cycle_num - last_pulse_cyc));
					pulse_count++;
					last_pulse_cyc = cycle_num;
				end
			end
			convst_q = convst;
		end
	end

	//////////////////////////////////////////////////
	// stimulus helpers

	task automatic start_conversions();
		@(negedge clk_in);
		conv_start = 1'b1;
		@(negedge clk_in);
		conv_start = 1'b0;
	endtask

	task automatic stop_conversions();
		@(negedge clk_in);
		conv_stop = 1'b1;
		@(negedge clk_in);
		conv_stop = 1'b0;
	endtask

	task automatic wait_pulses(int target);
		int waited;
		waited = 0;
		while (pulse_count < target && waited < PULSE_TIMEOUT) begin
			@(posedge clk_in);
			waited++;
		end
		if (pulse_count < target)
			note_failure($sformatf("timeout waiting for convst pulse %0d", target));
	endtask

	// pops n words and checks them against the stream
	task automatic check_words(int n);
		int           waited;
		sample_word_t got;
		for (int i = 0; i < n; i++) begin
			waited = 0;
			while (got_q.size() == 0 && waited < WORD_TIMEOUT) begin
				@(posedge clk_in);
				waited++;
			end
			if (got_q.size() == 0) begin
				note_failure($sformatf("timeout waiting for word %0d", word_num));
				return;
			end
			got = got_q.pop_front();
			compare_word("sample_word", got, expected_word(word_num));
			word_num++;
		end
	endtask

	task automatic check_idle_pins();
		@(negedge clk_in);
		compare_bit("convst", convst, 1'b1);
		compare_bit("n_cs", n_cs, 1'b1);
		compare_bit("sclk", sclk, 1'b0);
		compare_bit("sample_valid", sample_valid, 1'b0);
	endtask

	//////////////////////////////////////////////////
	// directed tests

	task automatic check_reset_state();
		check_idle_pins();
		compare_os("os", os, OS_MIN);
		compare_bit("adc_reset", adc_reset, 1'b0);
	endtask

	task automatic check_os_clamp();
		logic [2:0] vals [4];
		logic [2:0] exps [4];
		vals = '{3'd0, 3'd3, 3'd6, 3'd7};  // below, inside, edge, above
		exps = '{OS_MIN, 3'd3, 3'd6, OS_MAX};
		for (int i = 0; i < 4; i++) begin
			@(negedge clk_in);
			os_value  = vals[i];
			os_update = 1'b1;
			@(negedge clk_in);
			os_update = 1'b0;
			compare_os("os", os, exps[i]);
		end
	endtask

	task automatic single_conversion();
		int base_pulses;
		@(posedge clk_in);
		auto_credit = 1'b1;
		base_pulses = pulse_count;
		start_conversions();
		wait_pulses(base_pulses + 1);
		stop_conversions();                // well inside MIN_T_CYCLE
		check_words(N_CHAN);
		repeat (3 * MIN_T_CYCLE) @(posedge clk_in);
		if (pulse_count != base_pulses + 1)
			note_failure("more than one conversion after a single start");
		if (got_q.size() != 0)
			note_failure("extra words after a single conversion");
		check_idle_pins();
	endtask

	task automatic continuous_mode();
		int base_pulses;
		int pulses;
		@(posedge clk_in);
		auto_credit = 1'b1;
		base_pulses = pulse_count;
		start_conversions();
		wait_pulses(base_pulses + CONT_FRAMES);  // spacing checked by monitor
		stop_conversions();
		@(posedge clk_in);
		pulses = pulse_count - base_pulses;
		check_words(pulses * N_CHAN);
		repeat (2 * MIN_T_CYCLE) @(posedge clk_in);
		if (pulse_count - base_pulses != pulses)
			note_failure("convst pulsed after conv_stop");
		if (got_q.size() != 0)
			note_failure("extra words after continuous mode");
		check_idle_pins();
	endtask

	task automatic credit_backpressure();
		int base_pulses;
		int base_words;
		int pulses;
		int words;
		@(posedge clk_in);
		auto_credit = 1'b0;                // consumer holds every credit
		base_pulses = pulse_count;
		base_words  = words_seen;
		start_conversions();
		wait_pulses(base_pulses + 1);
		repeat (STALL_WINDOW) @(posedge clk_in);
		pulses = pulse_count - base_pulses;
		words  = words_seen - base_words;
		if (words > CREDIT_INIT)
			note_failure($sformatf("%0d words delivered without credit", words));
		if (pulses * N_CHAN - words <= BUF_DEPTH - N_CHAN)
			note_failure("convst stopped while the buffer still had room for a frame");
		repeat (STALL_WINDOW) @(posedge clk_in);
		if (pulse_count - base_pulses != pulses)
			note_failure("convst pulsed while the buffer had no room");
		stop_conversions();
		@(posedge clk_in);
		pulses        = pulse_count - base_pulses;
		extra_credits = CREDIT_INIT;       // grant again, then one per word
		auto_credit   = 1'b1;
		check_words(pulses * N_CHAN);
		repeat (2 * MIN_T_CYCLE) @(posedge clk_in);
		if (pulse_count - base_pulses != pulses)
			note_failure("convst pulsed after conv_stop while draining");
		if (got_q.size() != 0)
			note_failure("extra words after draining the buffer");
	endtask

	//////////////////////////////////////////////////
	// main sequence

	initial begin
		reset_in   = 1'b1;
		os_value   = 3'd0;
		os_update  = 1'b0;
		conv_start = 1'b0;
		conv_stop  = 1'b0;
		repeat (10) @(posedge clk_in);
		@(negedge clk_in);
		compare_bit("adc_reset", adc_reset, 1'b1);  // adc held with the logic
		reset_in = 1'b0;
		check_reset_state();
		check_os_clamp();
		single_conversion();
		continuous_mode();
		credit_backpressure();
		repeat (5) @(posedge clk_in);
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
		if (mismatch_count == 0 && fault_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== adc_acq_top.f ====
hw/adc_acq_pkg.sv
hw/adc_conv_ctrl.sv
hw/adc_serial_reader.sv
hw/adc_word_buffer.sv
hw/adc_acq_top.sv
verif/ad7608_model.sv
verif/tb_adc_acq.sv
